// ==== logic/fm_mix_settings.svh ====
`ifndef FM_MIX_SETTINGS_SVH
`define FM_MIX_SETTINGS_SVH

// Channels per operator group
`define FM_CHANNELS 6

// Slots in one full round, four groups of six
`define FM_SLOTS 24

// Stereo frames buffered ahead of the DAC
`define FIFO_DEPTH 8

// Credits held by the sender after reset
`define DAC_CREDITS 4

`endif

// ==== logic/fm_mix_pkg.sv ====
package fm_mix_pkg;

	// One operator output from the external pipeline
	typedef logic signed [8:0] op_t;

	// Channel sum, room for four carriers
	typedef logic signed [10:0] ch_sum_t;

	// One stereo side, six channels summed
	typedef logic signed [13:0] mix_t;

	// Channel index 0..5
	typedef logic [2:0] ch_t;

	// Operator connection algorithm
	typedef logic [2:0] alg_t;

	// Operator groups in the order the pipeline delivers them
	typedef enum logic [1:0] {
		GRP_S1 = 2'd0,	// Sum restart
		GRP_S3 = 2'd1,	// Frame accumulation
		GRP_S2 = 2'd2,	// Frame push on entry
		GRP_S4 = 2'd3	// Last group of the round
	} op_grp_e;

endpackage

// ==== logic/slot_timer.sv ====
`timescale 1ns/1ps
`include "fm_mix_settings.svh"

module slot_timer (
	input  logic                clk,
	input  logic                rst,
	output fm_mix_pkg::op_grp_e grp,	// Group of the operator in this slot
	output fm_mix_pkg::ch_t     ch	// Channel of the operator in this slot
);

	// The slot count is kept as group (upper) and channel (lower) fields
	fm_mix_pkg::op_grp_e grp_nx;
	logic                ch_wrap;

	assign ch_wrap = (ch == fm_mix_pkg::ch_t'(`FM_CHANNELS - 1));	// Last channel of group

	// Visiting order follows the operator pipeline delay
	always_comb begin
		case (grp)
			fm_mix_pkg::GRP_S1: grp_nx = fm_mix_pkg::GRP_S3;
			fm_mix_pkg::GRP_S3: grp_nx = fm_mix_pkg::GRP_S2;
			fm_mix_pkg::GRP_S2: grp_nx = fm_mix_pkg::GRP_S4;
			default:            grp_nx = fm_mix_pkg::GRP_S1;	// S4 wraps to next round
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			grp <= fm_mix_pkg::GRP_S1;	// Slot 0
			ch  <= '0;
		end else begin
			if (ch_wrap) begin
				ch  <= '0;
				grp <= grp_nx;	// Step group every six clocks
			end else begin
				ch <= ch + fm_mix_pkg::ch_t'(1);
			end
		end
	end

endmodule

// ==== logic/channel_regs.sv ====
`timescale 1ns/1ps
`include "fm_mix_settings.svh"

module channel_regs (
	input  logic             clk,
	input  logic             rst,
	input  logic             cfg_we,	// Config write strobe
	input  fm_mix_pkg::ch_t  cfg_ch,	// Channel being written
	input  fm_mix_pkg::alg_t cfg_alg,
	input  logic [1:0]       cfg_rl,	// Bit 1 left, bit 0 right
	input  logic             pcm_en_in,
	input  logic [7:0]       pcm_in,
	input  fm_mix_pkg::ch_t  ch,	// Current slot channel
	output fm_mix_pkg::alg_t alg,
	output logic [1:0]       rl,
	output logic             pcm_en,
	output logic [7:0]       pcm
);

	fm_mix_pkg::alg_t alg_r [`FM_CHANNELS];
	logic [1:0]       rl_r  [`FM_CHANNELS];
	logic             cfg_hit;

	assign cfg_hit = cfg_we && (cfg_ch < fm_mix_pkg::ch_t'(`FM_CHANNELS));	// Drop bad index

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `FM_CHANNELS; i++) begin
				alg_r[i] <= '0;	// Algorithm 0
				rl_r[i]  <= 2'b11;	// Both sides on
			end
			pcm_en <= 1'b0;
		end else begin
			if (cfg_hit) begin
				alg_r[cfg_ch] <= cfg_alg;
				rl_r[cfg_ch]  <= cfg_rl;
			end
			pcm_en <= pcm_en_in;
		end
	end

	always_ff @(posedge clk) pcm <= pcm_in;	// PCM sample, plain data

	assign alg = alg_r[ch];	// Entry for the channel in this slot
	assign rl  = rl_r[ch];

endmodule

// ==== logic/delay_line.sv ====
`timescale 1ns/1ps

module delay_line #(
	parameter int width  = 11,
	parameter int stages = 6
) (
	input  logic             clk,
	input  logic [width-1:0] din,
	output logic [width-1:0] dout	// din from stages clocks ago
);

	logic [width-1:0] sr [stages];

	always_ff @(posedge clk) begin
		sr[0] <= din;	// Entry stage
		for (int i = 1; i < stages; i++) begin
			sr[i] <= sr[i-1];	// Shift toward output
		end
	end

	assign dout = sr[stages-1];

endmodule

// ==== logic/op_accum.sv ====
`timescale 1ns/1ps
`include "fm_mix_settings.svh"

module op_accum (
	input  logic                clk,
	input  logic                rst,
	input  fm_mix_pkg::op_t     op_result,	// Operator output for this slot
	input  fm_mix_pkg::op_grp_e grp,
	input  fm_mix_pkg::ch_t     ch,
	input  fm_mix_pkg::alg_t    alg,	// Algorithm of current channel
	input  logic [1:0]          rl,	// Panning of current channel
	input  logic                pcm_en,
	input  logic [7:0]          pcm,
	output logic                push,	// One pulse per round
	output fm_mix_pkg::mix_t    push_left,
	output fm_mix_pkg::mix_t    push_right
);

	logic                sum_en;	// Operator is a carrier
	logic                pcm_sel;
	logic                frame_start, frame_last;
	fm_mix_pkg::ch_sum_t op_ext, carrier, next, total, done;
	fm_mix_pkg::mix_t    ch_val, pan_l, pan_r;
	fm_mix_pkg::mix_t    acc_l, acc_r, acc_l_nx, acc_r_nx;

	// Carrier selection per algorithm
	always_comb begin
		case (alg)
			3'd4:       sum_en = (grp == fm_mix_pkg::GRP_S2) || (grp == fm_mix_pkg::GRP_S4);
			3'd5, 3'd6: sum_en = (grp != fm_mix_pkg::GRP_S1);	// S3, S2, S4
			3'd7:       sum_en = 1'b1;	// All four
			default:    sum_en = (grp == fm_mix_pkg::GRP_S4);	// Algorithms 0..3
		endcase
	end

	assign op_ext  = {{2{op_result[8]}}, op_result};	// Sign extend to 11 bits
	assign carrier = sum_en ? op_ext : '0;
	assign next    = (grp == fm_mix_pkg::GRP_S1) ? carrier : carrier + total;	// Restart in S1

	// Running partial sum, one entry per channel
	delay_line #(.width(11), .stages(6)) u_sum (
		.clk  (clk),
		.din  (next),
		.dout (total)
	);

	// During S1 total is the completed sum; hold it one group for S3
	delay_line #(.width(11), .stages(6)) u_done (
		.clk  (clk),
		.din  (total),
		.dout (done)
	);

	assign pcm_sel = pcm_en && (ch == fm_mix_pkg::ch_t'(`FM_CHANNELS - 1));	// Channel 6 only
	assign ch_val  = pcm_sel ? fm_mix_pkg::mix_t'({6'd0, pcm}) - 14'd128	// Offset binary
	                         : {{3{done[10]}}, done};

	assign pan_l = rl[1] ? ch_val : '0;
	assign pan_r = rl[0] ? ch_val : '0;

	assign frame_start = (ch == '0);
	assign frame_last  = (ch == fm_mix_pkg::ch_t'(`FM_CHANNELS - 1));
	assign acc_l_nx    = (frame_start ? fm_mix_pkg::mix_t'(0) : acc_l) + pan_l;	// First loads
	assign acc_r_nx    = (frame_start ? fm_mix_pkg::mix_t'(0) : acc_r) + pan_r;

	// Frame accumulator and pushed frame
	always_ff @(posedge clk) begin
		if (grp == fm_mix_pkg::GRP_S3) begin
			acc_l <= acc_l_nx;
			acc_r <= acc_r_nx;
			if (frame_last) begin
				push_left  <= acc_l_nx;	// Complete frame
				push_right <= acc_r_nx;
			end
		end
	end

	// Pulse lands on the first S2 slot
	always_ff @(posedge clk) begin
		if (rst) begin
			push <= 1'b0;
		end else begin
			push <= (grp == fm_mix_pkg::GRP_S3) && frame_last;
		end
	end

endmodule

// ==== logic/sample_fifo.sv ====
`timescale 1ns/1ps
`include "fm_mix_settings.svh"

module sample_fifo (
	input  logic             clk,
	input  logic             rst,
	input  logic             push,
	input  fm_mix_pkg::mix_t push_left,
	input  fm_mix_pkg::mix_t push_right,
	input  logic             pop,	// Only when not empty
	output fm_mix_pkg::mix_t pop_left,	// Head entry
	output fm_mix_pkg::mix_t pop_right,
	output logic             empty,
	output logic             overflow	// Sticky until reset
);

	localparam int AW = $clog2(`FIFO_DEPTH);

	fm_mix_pkg::mix_t mem_l [`FIFO_DEPTH];
	fm_mix_pkg::mix_t mem_r [`FIFO_DEPTH];
	logic [AW-1:0]    wr_ptr, rd_ptr;
	logic [AW:0]      count;	// 0..FIFO_DEPTH
	logic             full, wr_en, rd_en;

	assign full  = (count == (AW+1)'(`FIFO_DEPTH));
	assign empty = (count == '0);
	assign wr_en = push && !full;	// Full drops the frame
	assign rd_en = pop && !empty;

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem_l[wr_ptr] <= push_left;
			mem_r[wr_ptr] <= push_right;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			count    <= '0;
			overflow <= 1'b0;
		end else begin
			if (wr_en) begin
				wr_ptr <= (wr_ptr == AW'(`FIFO_DEPTH - 1)) ? '0 : wr_ptr + AW'(1);
			end
			if (rd_en) begin
				rd_ptr <= (rd_ptr == AW'(`FIFO_DEPTH - 1)) ? '0 : rd_ptr + AW'(1);
			end
			case ({wr_en, rd_en})
				2'b10:   count <= count + (AW+1)'(1);
				2'b01:   count <= count - (AW+1)'(1);
				default: count <= count;	// Both or neither
			endcase
			if (push && full) begin
				overflow <= 1'b1;	// Lost frame
			end
		end
	end

	assign pop_left  = mem_l[rd_ptr];
	assign pop_right = mem_r[rd_ptr];

endmodule

// ==== logic/credit_sender.sv ====
`timescale 1ns/1ps
`include "fm_mix_settings.svh"

module credit_sender (
	input  logic             clk,
	input  logic             rst,
	input  logic             empty,
	input  fm_mix_pkg::mix_t pop_left,
	input  fm_mix_pkg::mix_t pop_right,
	input  logic             snd_credit,	// One credit back per pulse
	output logic             pop,
	output logic             snd_valid,	// One clock per sample
	output fm_mix_pkg::mix_t snd_left,
	output fm_mix_pkg::mix_t snd_right
);

	localparam int CW = $clog2(`DAC_CREDITS + 1);

	logic [CW-1:0] credits;	// Samples the DAC can still take

	assign pop = !empty && (credits != '0);

	always_ff @(posedge clk) begin
		if (rst) begin
			credits   <= CW'(`DAC_CREDITS);	// Full allowance
			snd_valid <= 1'b0;
		end else begin
			case ({snd_credit, pop})
				2'b10:   credits <= credits + CW'(1);	// Returned
				2'b01:   credits <= credits - CW'(1);	// Spent
				default: credits <= credits;	// Return and spend cancel
			endcase
			snd_valid <= pop;
		end
	end

	// Sample registered with its valid
	always_ff @(posedge clk) begin
		if (pop) begin
			snd_left  <= pop_left;
			snd_right <= pop_right;
		end
	end

endmodule

// ==== logic/fm_mix_top.sv ====
`timescale 1ns/1ps

module fm_mix_top (
	input  logic             clk,
	input  logic             rst,
	input  fm_mix_pkg::op_t  op_result,
	input  logic             cfg_we,
	input  fm_mix_pkg::ch_t  cfg_ch,
	input  fm_mix_pkg::alg_t cfg_alg,
	input  logic [1:0]       cfg_rl,
	input  logic             pcm_en,
	input  logic [7:0]       pcm,
	input  logic             snd_credit,
	output logic             snd_valid,
	output fm_mix_pkg::mix_t snd_left,
	output fm_mix_pkg::mix_t snd_right,
	output logic             overflow
);

	fm_mix_pkg::op_grp_e grp;	// Slot position
	fm_mix_pkg::ch_t     ch;
	fm_mix_pkg::alg_t    cur_alg;	// Current channel config
	logic [1:0]          cur_rl;
	logic                cur_pcm_en;	// Registered PCM controls
	logic [7:0]          cur_pcm;
	logic                push;	// Producer to FIFO
	fm_mix_pkg::mix_t    push_left, push_right;
	logic                pop, empty;	// FIFO to sender
	fm_mix_pkg::mix_t    pop_left, pop_right;

	slot_timer u_slot_timer (
		.clk (clk),
		.rst (rst),
		.grp (grp),
		.ch  (ch)
	);

	channel_regs u_channel_regs (
		.clk       (clk),
		.rst       (rst),
		.cfg_we    (cfg_we),
		.cfg_ch    (cfg_ch),
		.cfg_alg   (cfg_alg),
		.cfg_rl    (cfg_rl),
		.pcm_en_in (pcm_en),
		.pcm_in    (pcm),
		.ch        (ch),
		.alg       (cur_alg),
		.rl        (cur_rl),
		.pcm_en    (cur_pcm_en),
		.pcm       (cur_pcm)
	);

	op_accum u_op_accum (
		.clk        (clk),
		.rst        (rst),
		.op_result  (op_result),
		.grp        (grp),
		.ch         (ch),
		.alg        (cur_alg),
		.rl         (cur_rl),
		.pcm_en     (cur_pcm_en),
		.pcm        (cur_pcm),
		.push       (push),
		.push_left  (push_left),
		.push_right (push_right)
	);

	sample_fifo u_sample_fifo (
		.clk        (clk),
		.rst        (rst),
		.push       (push),
		.push_left  (push_left),
		.push_right (push_right),
		.pop        (pop),
		.pop_left   (pop_left),
		.pop_right  (pop_right),
		.empty      (empty),
		.overflow   (overflow)
	);

	credit_sender u_credit_sender (
		.clk        (clk),
		.rst        (rst),
		.empty      (empty),
		.pop_left   (pop_left),
		.pop_right  (pop_right),
		.snd_credit (snd_credit),
		.pop        (pop),
		.snd_valid  (snd_valid),
		.snd_left   (snd_left),
		.snd_right  (snd_right)
	);

endmodule

// ==== tb/tb_fm_mix.sv ====
`timescale 1ns/1ps
`include "fm_mix_settings.svh"

module tb_fm_mix;

	localparam int frame_budget = 110;	// Rounds used by all tests together
	localparam int round_clks   = `FM_SLOTS;

	logic                clk, rst, rst_seen;
	fm_mix_pkg::op_t     op_result;
	logic                cfg_we, pcm_en, snd_credit, snd_valid, overflow;
	fm_mix_pkg::ch_t     cfg_ch;
	fm_mix_pkg::alg_t    cfg_alg;
	logic [1:0]          cfg_rl;
	logic [7:0]          pcm;
	fm_mix_pkg::mix_t    snd_left, snd_right;

	int         tbl [`FM_CHANNELS][4];	// Operator value per channel and group
	int         m_alg [`FM_CHANNELS];	// Model of the channel config
	logic [1:0] m_rl [`FM_CHANNELS];
	logic       m_pcm_en;
	int         m_pcm;
	int         slot, seed, errors, checks;
	int         owed, rx_count;	// Uncredited and received sample counts
	logic       credit_on;	// DAC returns credits

	fm_mix_top u_dut (
		.clk        (clk),
		.rst        (rst),
		.op_result  (op_result),
		.cfg_we     (cfg_we),
		.cfg_ch     (cfg_ch),
		.cfg_alg    (cfg_alg),
		.cfg_rl     (cfg_rl),
		.pcm_en     (pcm_en),
		.pcm        (pcm),
		.snd_credit (snd_credit),
		.snd_valid  (snd_valid),
		.snd_left   (snd_left),
		.snd_right  (snd_right),
		.overflow   (overflow)
	);

	always #50 clk = ~clk;	// 100 ns period

	// Own slot counter drives the operator value for the DUT's current slot
	always begin
		@(posedge clk);
		rst_seen = rst;	// Level the DUT saw at this edge
		#1;
		slot = rst_seen ? 0 : (slot + 1) % `FM_SLOTS;
		op_result = fm_mix_pkg::op_t'(tbl[slot % `FM_CHANNELS][slot / `FM_CHANNELS]);
	end

	always @(negedge clk) begin
		if (snd_valid) begin
			owed++;
			rx_count++;
		end
	end

	// DAC model returns one credit per cycle while enabled
	always begin
		@(posedge clk);
		#1;
		if (credit_on && owed > 0) begin
			snd_credit = 1'b1;
			owed--;
		end else begin
			snd_credit = 1'b0;
		end
	end

	initial begin
		#((frame_budget + 40) * round_clks * 100);	// All rounds plus margin
		$display("Timeout: the tests ran past their cycle budget");
		$display("Checks: %0d, errors: %0d", checks, errors);
		$display("Something failed");
		$finish;
	end

	function automatic bit is_carrier(input int a, input int g);
		case (a)
			4:       return (g == int'(fm_mix_pkg::GRP_S2)) || (g == int'(fm_mix_pkg::GRP_S4));
			5, 6:    return g != int'(fm_mix_pkg::GRP_S1);
			7:       return 1'b1;
			default: return g == int'(fm_mix_pkg::GRP_S4);	// Algorithms 0..3
		endcase
	endfunction

	function automatic int channel_value(input int c);
		int s = 0;
		if (c == `FM_CHANNELS - 1 && m_pcm_en) return m_pcm - 128;	// Offset binary PCM
		for (int g = 0; g < 4; g++) begin
			if (is_carrier(m_alg[c], g)) s += tbl[c][g];
		end
		return s;
	endfunction

	function automatic int expected_side(input int side);	// Index of the rl bit, left is 1
		int s = 0;
		for (int c = 0; c < `FM_CHANNELS; c++) begin
			if (m_rl[c][side]) s += channel_value(c);
		end
		return s;
	endfunction

	task automatic write_cfg(input int c, input int a, input logic [1:0] p);
		@(posedge clk);
		#1;
		cfg_we  = 1'b1;
		cfg_ch  = fm_mix_pkg::ch_t'(c);
		cfg_alg = fm_mix_pkg::alg_t'(a);
		cfg_rl  = p;
		m_alg[c] = a;
		m_rl[c]  = p;
		@(posedge clk);
		#1;
		cfg_we = 1'b0;
	endtask

	task automatic set_pcm(input logic en, input int v);
		@(posedge clk);
		#1;
		pcm_en   = en;
		pcm      = 8'(v);
		m_pcm_en = en;
		m_pcm    = v;
	endtask

	task automatic get_sample(output fm_mix_pkg::mix_t l, output fm_mix_pkg::mix_t r,
			output bit ok);
		ok = 1'b0;
		for (int i = 0; i < 3 * round_clks && !ok; i++) begin
			@(negedge clk);	// Outputs settled mid-cycle
			if (snd_valid) begin
				ok = 1'b1;
				l  = snd_left;
				r  = snd_right;
			end
		end
	endtask

	task automatic compare_next;
		fm_mix_pkg::mix_t l, r, el, er;
		bit               ok;
		el = fm_mix_pkg::mix_t'(expected_side(1));
		er = fm_mix_pkg::mix_t'(expected_side(0));
		get_sample(l, r, ok);
		checks++;
		assert (ok) else begin
			errors++;
			$display("No sample arrived within three rounds");
		end
		if (ok) begin
			assert (l == el) else begin
				errors++;
				$display("** Error: snd_left = %h, expected %h", l, el);
			end
			assert (r == er) else begin
				errors++;
				$display("** Error: snd_right = %h, expected %h", r, er);
			end
		end
	endtask

	task automatic check_frames(input int n);
		credit_on = 1'b1;
		repeat (3 * round_clks) @(posedge clk);	// Drop frames of older rounds
		repeat (n) compare_next();
	endtask

	task automatic startup_limits;
		bit seen = 1'b0;
		int n    = 0;
		for (int i = 0; i < 3 * round_clks && !seen; i++) begin
			@(negedge clk);
			checks++;
			if (snd_valid) begin
				seen = 1'b1;
				assert (i > 2 * `FM_CHANNELS) else begin	// First push lands in slot 12
					errors++;
					$display("A sample arrived before the first frame was pushed");
				end
			end
			assert (!overflow) else begin
				errors++;
				$display("** Error: overflow = %h, expected %h", overflow, 1'b0);
			end
		end
		assert (seen) else begin
			errors++;
			$display("No sample after reset");
		end
		n = 1;
		repeat (8 * round_clks) begin	// No credits go back here
			@(negedge clk);
			if (snd_valid) n++;
		end
		checks++;
		assert (n <= `DAC_CREDITS) else begin
			errors++;
			$display("More samples than initial credits arrived: %0d", n);
		end
	endtask

	task automatic algorithm_sweep;
		for (int a = 0; a < 8; a++) begin
			for (int c = 0; c < `FM_CHANNELS; c++) write_cfg(c, a, 2'b11);
			check_frames(2);
		end
	endtask

	task automatic panning_mix;
		write_cfg(0, 7, 2'b11);
		write_cfg(1, 4, 2'b10);	// Left only
		write_cfg(2, 5, 2'b01);	// Right only
		write_cfg(3, 0, 2'b00);	// Muted
		write_cfg(4, 6, 2'b10);
		write_cfg(5, 2, 2'b01);
		check_frames(3);
	endtask

	task automatic pcm_substitution;
		write_cfg(5, 7, 2'b11);
		set_pcm(1'b1, 0);
		check_frames(2);
		set_pcm(1'b1, 128);	// Midscale adds nothing
		check_frames(2);
		set_pcm(1'b1, 255);
		check_frames(2);
		set_pcm(1'b1, 77);
		check_frames(2);
	endtask

	task automatic backpressure_drain;
		int n0;
		int vals [`DAC_CREDITS + `FIFO_DEPTH + 2];	// PCM value of each withheld round
		for (int i = 0; i < 4 * round_clks; i++) begin	// Quiet round start with credits home
			@(posedge clk);
			#2;
			if (owed == 0 && !snd_valid && slot == 0) break;
		end
		credit_on = 1'b0;
		n0 = rx_count;
		for (int r = 0; r < `DAC_CREDITS + `FIFO_DEPTH + 2; r++) begin
			vals[r] = r * 17 + 3;	// Distinct frame per round
			set_pcm(1'b1, vals[r]);
			repeat (round_clks - 1) @(posedge clk);
		end
		#2;
		checks++;
		assert (rx_count - n0 == `DAC_CREDITS) else begin
			errors++;
			$display("** Error: samples = %h, expected %h", rx_count - n0, `DAC_CREDITS);
		end
		assert (overflow) else begin
			errors++;
			$display("** Error: overflow = %h, expected %h", overflow, 1'b1);
		end
		credit_on = 1'b1;
		for (int k = 0; k < `FIFO_DEPTH; k++) begin	// Buffered rounds follow the credited ones
			m_pcm = vals[`DAC_CREDITS + k];
			compare_next();
		end
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		op_result = '0;
		cfg_we = 1'b0;
		cfg_ch = '0;
		cfg_alg = '0;
		cfg_rl = 2'b00;
		pcm_en = 1'b0;
		pcm = 8'd0;
		snd_credit = 1'b0;
		credit_on = 1'b0;
		{slot, owed, rx_count, errors, checks} = '0;
		m_pcm_en = 1'b0;
		m_pcm = 0;
		seed = 32'h568d_8f26;
		for (int c = 0; c < `FM_CHANNELS; c++) begin
			m_alg[c] = 0;	// DUT reset values
			m_rl[c]  = 2'b11;
			for (int g = 0; g < 4; g++) tbl[c][g] = $random(seed) % 201;	// Within +-200
		end
		repeat (16) @(posedge clk);
		#1;
		rst = 1'b0;
		startup_limits();
		algorithm_sweep();
		panning_mix();
		pcm_substitution();
		backpressure_drain();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

// ==== flist.f ====
+incdir+logic
logic/fm_mix_pkg.sv
logic/slot_timer.sv
logic/channel_regs.sv
logic/delay_line.sv
logic/op_accum.sv
logic/sample_fifo.sv
logic/credit_sender.sv
logic/fm_mix_top.sv
tb/tb_fm_mix.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the FM mixer testbench with Verilator, verdict from the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_fm_mix \
	-f flist.f -o tb_fm_mix > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/tb_fm_mix > sim.log 2>&1
cat sim.log

grep -q "Something failed" sim.log && echo "Simulation FAILED" && exit 1
grep -q "Everything OK" sim.log || { echo "Simulation ended without a verdict"; exit 1; }
echo "Simulation passed"
